// File: ilk_pkt_gen_top.f
+incdir+src
src/ilk_gen_pkg.sv
src/ilk_size_gen.sv
src/ilk_seg_seq.sv
src/ilk_word_fmt.sv
src/ilk_tx_stats.sv
src/ilk_pkt_gen_top.sv
verif/ilk_pkt_gen_chk.sv
verif/tb_ilk_pkt_gen.sv

// File: src/ilk_gen_consts.svh
// Interlaken packet generator constants
// Bus widths, packet sizing and payload pattern values

`ifndef ILK_GEN_CONSTS_SVH
`define ILK_GEN_CONSTS_SVH

// Transmit bus width and the number of 64-bit words in one beat
`define ILK_DATA_W 512
`define ILK_WORDS 8

// Packet size in bytes
`define ILK_SIZE_W 14

// Size used when random sizing is off
`define ILK_FIXED_SIZE 65

// Value loaded into the size LFSR on reset
`define ILK_LFSR_SEED 65

// Width of the SOP and EOP statistics counters
`define ILK_CNT_W 32

// Byte step between consecutive base words of the payload pattern
`define ILK_WORD_STEP 16

`endif

// File: src/ilk_gen_pkg.sv
// Interlaken packet generator types
// Field widths, the packet descriptor, the beat control word and FSM states

`include "ilk_gen_consts.svh"

package ilk_gen_pkg;

   typedef logic [`ILK_SIZE_W-1:0] pkt_size_t;

   typedef logic [7:0] beat_cnt_t;

   // Valid 64-bit words in a beat, zero marks an idle beat
   typedef logic [3:0] nvalid_t;

   // Bit 3 flags EOP, bits 2:0 hold the last word's byte count with 0 meaning 8
   typedef logic [3:0] eopbits_t;

   typedef logic [7:0] chan_t;

   typedef logic [3:0] offset_t;

   typedef struct packed {
      beat_cnt_t beats;
      nvalid_t   last_valid;
      eopbits_t  eopbits;
   } pkt_desc_t;

   typedef struct packed {
      logic     sop;
      eopbits_t eopbits;
      nvalid_t  num_valid;
      chan_t    chan;
      offset_t  offset;
   } beat_ctl_t;

   typedef enum logic [1:0] {
      INIT,
      SOP,
      PLD,
      EOP
   } seq_state_t;

endpackage

// File: src/ilk_pkt_gen_top.sv
// Interlaken transmit packet generator
// Size stage, sequencer and formatter in a pipeline, with beat statistics

`timescale 1ns/1ps
`include "ilk_gen_consts.svh"

module ilk_pkt_gen_top
   import ilk_gen_pkg::*;
(
   input  logic                   clk,
   input  logic                   tx_usr_srst,
   input  logic                   rx_lanes_aligned,
   input  logic                   send_data,
   input  logic                   rand_size,
   input  logic                   itx_ready,
   output logic [`ILK_DATA_W-1:0] itx_din_words,
   output nvalid_t                itx_num_valid,
   output logic                   itx_sop,
   output eopbits_t               itx_eopbits,
   output chan_t                  itx_chan,
   output logic [`ILK_CNT_W-1:0]  tx_sop_cnt,
   output logic [`ILK_CNT_W-1:0]  tx_eop_cnt
);

   pkt_desc_t desc;
   logic      take;
   beat_ctl_t beat;

   ilk_size_gen u_size_gen (
      .clk         (clk),
      .tx_usr_srst (tx_usr_srst),
      .rand_size   (rand_size),
      .take        (take),
      .desc        (desc)
   );

   ilk_seg_seq u_seg_seq (
      .clk              (clk),
      .tx_usr_srst      (tx_usr_srst),
      .rx_lanes_aligned (rx_lanes_aligned),
      .send_data        (send_data),
      .itx_ready        (itx_ready),
      .desc             (desc),
      .take             (take),
      .beat             (beat)
   );

   ilk_word_fmt u_word_fmt (
      .clk           (clk),
      .tx_usr_srst   (tx_usr_srst),
      .beat          (beat),
      .itx_din_words (itx_din_words),
      .itx_num_valid (itx_num_valid),
      .itx_sop       (itx_sop),
      .itx_eopbits   (itx_eopbits),
      .itx_chan      (itx_chan)
   );

   // Statistics watch the registered port signals
   ilk_tx_stats u_tx_stats (
      .clk           (clk),
      .tx_usr_srst   (tx_usr_srst),
      .itx_sop       (itx_sop),
      .itx_eopbits   (itx_eopbits),
      .itx_num_valid (itx_num_valid),
      .tx_sop_cnt    (tx_sop_cnt),
      .tx_eop_cnt    (tx_eop_cnt)
   );

endmodule

// File: src/ilk_seg_seq.sv
// Packet sequencer
// Splits each packet into SOP, payload and EOP beats under itx_ready control

`timescale 1ns/1ps
`include "ilk_gen_consts.svh"

module ilk_seg_seq
   import ilk_gen_pkg::*;
(
   input  logic      clk,
   input  logic      tx_usr_srst,
   input  logic      rx_lanes_aligned,
   input  logic      send_data,
   input  logic      itx_ready,
   input  pkt_desc_t desc,
   output logic      take,
   output beat_ctl_t beat
);

   logic       en_meta;
   logic       en_sync;
   seq_state_t state;
   beat_cnt_t  pld_left;
   nvalid_t    last_valid;
   eopbits_t   last_eopbits;
   chan_t      chan;
   offset_t    offset;

   // The size stage moves to the next packet on the same edge as the SOP beat
   assign take = (state == SOP) && itx_ready;

   // Enable comes from another domain
   always_ff @(posedge clk or posedge tx_usr_srst) begin
      if (tx_usr_srst) begin
         en_meta <= 1'b0;
         en_sync <= 1'b0;
      end else begin
         en_meta <= rx_lanes_aligned && send_data;
         en_sync <= en_meta;
      end
   end

   always_ff @(posedge clk or posedge tx_usr_srst) begin
      if (tx_usr_srst) begin
         state        <= INIT;
         pld_left     <= '0;
         last_valid   <= '0;
         last_eopbits <= '0;
         chan         <= '0;
         offset       <= '0;
         beat         <= '0;
      end else begin
         // Idle beat unless a ready cycle below fills it in
         beat.sop       <= 1'b0;
         beat.eopbits   <= '0;
         beat.num_valid <= '0;
         beat.chan      <= chan;
         beat.offset    <= offset;

         case (state)
            INIT: begin
               if (en_sync && itx_ready) begin
                  state <= SOP;
               end
            end

            SOP: begin
               if (itx_ready) begin
                  beat.sop    <= 1'b1;
                  beat.offset <= '0;
                  offset      <= offset_t'(2);
                  if (desc.beats == beat_cnt_t'(1)) begin
                     // Short packet, SOP and EOP share the beat
                     beat.num_valid <= desc.last_valid;
                     beat.eopbits   <= desc.eopbits;
                     chan           <= chan + chan_t'(1);
                     state          <= en_sync ? SOP : INIT;
                  end else begin
                     beat.num_valid <= nvalid_t'(`ILK_WORDS);
                     // The descriptor changes next cycle, keep the tail fields
                     last_valid     <= desc.last_valid;
                     last_eopbits   <= desc.eopbits;
                     pld_left       <= desc.beats - beat_cnt_t'(2);
                     state          <= (desc.beats == beat_cnt_t'(2)) ? EOP : PLD;
                  end
               end
            end

            PLD: begin
               if (itx_ready) begin
                  beat.num_valid <= nvalid_t'(`ILK_WORDS);
                  offset         <= offset + offset_t'(2);
                  pld_left       <= pld_left - beat_cnt_t'(1);
                  if (pld_left == beat_cnt_t'(1)) begin
                     state <= EOP;
                  end
               end
            end

            EOP: begin
               if (itx_ready) begin
                  beat.num_valid <= last_valid;
                  beat.eopbits   <= last_eopbits;
                  offset         <= offset + offset_t'(2);
                  chan           <= chan + chan_t'(1);
                  // A dropped enable stops only before the next SOP
                  state          <= en_sync ? SOP : INIT;
               end
            end

            default: state <= INIT;
         endcase
      end
   end

endmodule

// File: src/ilk_size_gen.sv
// Packet size stage
// Picks a fixed or LFSR size and turns it into a beat-level descriptor

`timescale 1ns/1ps
`include "ilk_gen_consts.svh"

module ilk_size_gen
   import ilk_gen_pkg::*;
(
   input  logic      clk,
   input  logic      tx_usr_srst,
   input  logic      rand_size,
   input  logic      take,
   output pkt_desc_t desc
);

   logic [6:0] lfsr;
   logic       lfsr_fb;
   pkt_size_t  size;
   logic [5:0] size_rem;

   assign lfsr_fb = ~(lfsr[6] ^ lfsr[4] ^ lfsr[3] ^ lfsr[2]);

   // The LFSR steps once per packet, whichever size source is selected
   always_ff @(posedge clk or posedge tx_usr_srst) begin
      if (tx_usr_srst) begin
         lfsr <= 7'(`ILK_LFSR_SEED);
      end else if (take) begin
         lfsr <= {lfsr[5:0], lfsr_fb};
      end
   end

   // Random sizes run from 1 to 128 bytes
   assign size = rand_size ? pkt_size_t'(lfsr) + pkt_size_t'(1)
                           : pkt_size_t'(`ILK_FIXED_SIZE);

   assign size_rem = size[5:0];

   always_comb begin
      // Whole 64-byte beats plus one more for any remainder
      desc.beats = beat_cnt_t'(size[`ILK_SIZE_W-1:6]) + beat_cnt_t'(|size_rem);

      // A full last beat carries all eight words
      if (size_rem == 6'd0) begin
         desc.last_valid = nvalid_t'(`ILK_WORDS);
      end else begin
         desc.last_valid = nvalid_t'(size_rem[5:3]) + nvalid_t'(|size_rem[2:0]);
      end

      desc.eopbits = {1'b1, size[2:0]};
   end

endmodule

// File: src/ilk_tx_stats.sv
// Transmit statistics
// Counts SOP and EOP beats as they leave on the core bus

`timescale 1ns/1ps
`include "ilk_gen_consts.svh"

module ilk_tx_stats
   import ilk_gen_pkg::*;
(
   input  logic                  clk,
   input  logic                  tx_usr_srst,
   input  logic                  itx_sop,
   input  eopbits_t              itx_eopbits,
   input  nvalid_t               itx_num_valid,
   output logic [`ILK_CNT_W-1:0] tx_sop_cnt,
   output logic [`ILK_CNT_W-1:0] tx_eop_cnt
);

   logic beat_vld;

   assign beat_vld = (itx_num_valid != '0);

   always_ff @(posedge clk or posedge tx_usr_srst) begin
      if (tx_usr_srst) begin
         tx_sop_cnt <= '0;
         tx_eop_cnt <= '0;
      end else begin
         if (beat_vld && itx_sop) begin
            tx_sop_cnt <= tx_sop_cnt + 1'b1;
         end
         if (beat_vld && itx_eopbits[3]) begin
            tx_eop_cnt <= tx_eop_cnt + 1'b1;
         end
      end
   end

endmodule

// File: src/ilk_word_fmt.sv
// Transmit word formatter
// Builds the payload pattern for a beat and registers it onto the core bus

`timescale 1ns/1ps
`include "ilk_gen_consts.svh"

module ilk_word_fmt
   import ilk_gen_pkg::*;
(
   input  logic                   clk,
   input  logic                   tx_usr_srst,
   input  beat_ctl_t              beat,
   output logic [`ILK_DATA_W-1:0] itx_din_words,
   output nvalid_t                itx_num_valid,
   output logic                   itx_sop,
   output eopbits_t               itx_eopbits,
   output chan_t                  itx_chan
);

   logic [`ILK_DATA_W-1:0] pattern;
   offset_t                offset_lo;

   assign offset_lo = beat.offset + offset_t'(1);

   // Word w holds bytes w*16+j; upper half XORs the offset, lower half offset+1
   always_comb begin
      for (int w = 0; w < `ILK_WORDS; w++) begin
         for (int j = 0; j < 8; j++) begin
            pattern[w*64 + j*8 +: 8] = 8'(w * `ILK_WORD_STEP + j) ^
               {4'h0, (w >= `ILK_WORDS / 2) ? beat.offset : offset_lo};
         end
      end
   end

   // Data only moves with a real beat
   always_ff @(posedge clk) begin
      if (beat.num_valid != '0) begin
         itx_din_words <= pattern;
      end
   end

   always_ff @(posedge clk or posedge tx_usr_srst) begin
      if (tx_usr_srst) begin
         itx_num_valid <= '0;
         itx_sop       <= 1'b0;
         itx_eopbits   <= '0;
         itx_chan      <= '0;
      end else if (beat.num_valid != '0) begin
         itx_num_valid <= beat.num_valid;
         itx_sop       <= beat.sop;
         itx_eopbits   <= beat.eopbits;
         itx_chan      <= beat.chan;
      end else begin
         itx_num_valid <= '0;
         itx_sop       <= 1'b0;
         itx_eopbits   <= '0;
         itx_chan      <= '0;
      end
   end

endmodule

// File: verif/ilk_pkt_gen_chk.sv
// Protocol checker for the packet generator
// Bound to the top level to watch the transmit bus for framing errors

`timescale 1ns/1ps
`include "ilk_gen_consts.svh"

module ilk_pkt_gen_chk
   import ilk_gen_pkg::*;
(
   input logic      clk,
   input logic      tx_usr_srst,
   input logic      rand_size,
   input nvalid_t   itx_num_valid,
   input logic      itx_sop,
   input eopbits_t  itx_eopbits,
   input logic      take,
   input beat_ctl_t beat
);

   int         fail_cnt = 0;
   logic [6:0] m_lfsr;
   int         m_size;
   int         m_tail;
   nvalid_t    m_words;
   nvalid_t    lv_take;
   nvalid_t    lv_port;
   logic       in_pkt;

   // Expected word count of the last beat for the packet the size stage offers now
   always_comb begin
      m_size  = rand_size ? int'(m_lfsr) + 1 : `ILK_FIXED_SIZE;
      m_tail  = (m_size % 64 == 0) ? 64 : m_size % 64;
      m_words = nvalid_t'((m_tail + 7) / 8);
   end

   // The expected last-beat word count follows the packet from the size stage to the ports
   always_ff @(posedge clk or posedge tx_usr_srst) begin
      if (tx_usr_srst) begin
         m_lfsr  <= 7'(`ILK_LFSR_SEED);
         lv_take <= '0;
         lv_port <= '0;
         in_pkt  <= 1'b0;
      end else begin
         if (take) begin
            m_lfsr  <= {m_lfsr[5:0], ~(m_lfsr[6] ^ m_lfsr[4] ^ m_lfsr[3] ^ m_lfsr[2])};
            lv_take <= m_words;
         end
         if (beat.sop && beat.num_valid != '0) begin
            lv_port <= lv_take;
         end
         if (itx_num_valid != '0) begin
            in_pkt <= !itx_eopbits[3];
         end
      end
   end

   a_idle_clean: assert property (@(posedge clk) disable iff (tx_usr_srst)
      (itx_num_valid == '0) |-> (!itx_sop && !itx_eopbits[3]))
      else begin
         $error("idle beat carries SOP or EOP");
         fail_cnt++;
      end

   a_nvalid_max: assert property (@(posedge clk) disable iff (tx_usr_srst)
      itx_num_valid <= nvalid_t'(`ILK_WORDS))
      else begin
         $error("num_valid above %0d", `ILK_WORDS);
         fail_cnt++;
      end

   a_eop_words: assert property (@(posedge clk) disable iff (tx_usr_srst)
      (itx_num_valid != '0 && itx_eopbits[3]) |-> (itx_num_valid == lv_port))
      else begin
         $error("EOP beat word count does not match the packet size");
         fail_cnt++;
      end

   a_sop_order: assert property (@(posedge clk) disable iff (tx_usr_srst)
      (itx_num_valid != '0 && itx_sop) |-> !in_pkt)
      else begin
         $error("SOP before the previous packet ended");
         fail_cnt++;
      end

endmodule

// File: verif/tb_ilk_pkt_gen.sv
// Testbench for the Interlaken transmit packet generator
// Random stimulus with a packet model that checks every beat on the bus

`timescale 1ns/1ps
`include "ilk_gen_consts.svh"

module tb_ilk_pkt_gen
   import ilk_gen_pkg::*;
();

   localparam int N_FIXED = 20;
   localparam int N_RAND = 300;
   localparam int N_ENABLE = 10;
   localparam int N_RESET = 4;
   localparam int TIMEOUT_CYCLES = (N_FIXED + N_RAND + N_ENABLE + N_RESET) * 5 * 4 + 200;

   logic                   clk;
   logic                   tx_usr_srst;
   logic                   rx_lanes_aligned;
   logic                   send_data;
   logic                   rand_size;
   logic                   itx_ready;
   logic [`ILK_DATA_W-1:0] itx_din_words;
   nvalid_t                itx_num_valid;
   logic                   itx_sop;
   eopbits_t               itx_eopbits;
   chan_t                  itx_chan;
   logic [`ILK_CNT_W-1:0]  tx_sop_cnt;
   logic [`ILK_CNT_W-1:0]  tx_eop_cnt;

   // Model state is rebuilt from the seed on every reset
   logic [6:0] m_lfsr;
   chan_t      m_chan;
   int         beat_idx = 0;
   int         exp_size = 0;
   int         bytes = 0;
   int         pkt_cnt = 0;
   int         sop_beats = 0;
   int         first_len = 0;
   int         chan_err = 0;
   int         err_cnt = 0;
   int         chk_seen = 0;
   int         test_err0 = 0;
   int         test_cnt = 0;
   int         fail_tests = 0;
   int         cycles = 0;
   int         p0;
   int         s0;

   ilk_pkt_gen_top dut0 (.*);

   bind ilk_pkt_gen_top ilk_pkt_gen_chk u_chk (
      .clk           (clk),
      .tx_usr_srst   (tx_usr_srst),
      .rand_size     (rand_size),
      .itx_num_valid (itx_num_valid),
      .itx_sop       (itx_sop),
      .itx_eopbits   (itx_eopbits),
      .take          (take),
      .beat          (beat)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic value_error(input string name, input logic [511:0] got,
                              input logic [511:0] exp);
      $display("ERROR %s: got %0h, expected %0h", name, got, exp);
      err_cnt++;
   endtask

   task automatic report_fault(input string what);
      $display("Failure at %0t: %s", $time, what);
      err_cnt++;
   endtask

   // Base word w holds bytes (w-1)*16+j XORed with off in the upper half and off+1 below
   function automatic logic [511:0] expected_pattern(input offset_t off);
      logic [511:0] d;
      offset_t      k;
      for (int w = 1; w <= 8; w++) begin
         k = (w >= 5) ? off : offset_t'(off + 1);
         for (int j = 0; j < 8; j++) begin
            d[(w-1)*64 + j*8 +: 8] = 8'((w - 1) * 16 + j) ^ {4'h0, k};
         end
      end
      return d;
   endfunction

   task automatic check_beat();
      int rem;
      if (beat_idx == 0) begin
         if (!itx_sop) report_fault("first beat of a packet has no SOP");
         exp_size = rand_size ? int'(m_lfsr) + 1 : `ILK_FIXED_SIZE;
         m_lfsr = {m_lfsr[5:0], ~(m_lfsr[6] ^ m_lfsr[4] ^ m_lfsr[3] ^ m_lfsr[2])};
         bytes = 0;
      end else if (itx_sop) begin
         report_fault("SOP inside a packet");
      end
      if (itx_sop) sop_beats++;
      if (itx_chan !== m_chan) begin
         value_error("itx_chan", itx_chan, m_chan);
         chan_err++;
      end
      if (itx_din_words !== expected_pattern(offset_t'(2 * beat_idx)))
         value_error("itx_din_words", itx_din_words, expected_pattern(offset_t'(2 * beat_idx)));
      if (beat_idx == (exp_size + 63) / 64 - 1) begin
         rem = (exp_size % 64 == 0) ? 64 : exp_size % 64;
         if (itx_num_valid !== nvalid_t'((rem + 7) / 8))
            value_error("itx_num_valid", itx_num_valid, (rem + 7) / 8);
         if (itx_eopbits !== eopbits_t'(8 + exp_size % 8))
            value_error("itx_eopbits", itx_eopbits, 8 + exp_size % 8);
         bytes += (int'(itx_num_valid) - 1) * 8 +
                  ((itx_eopbits[2:0] == 3'd0) ? 8 : int'(itx_eopbits[2:0]));
         if (bytes != exp_size) value_error("packet length", bytes, exp_size);
         if (pkt_cnt == 0) first_len = bytes;
         m_chan++;
         pkt_cnt++;
         beat_idx = 0;
      end else begin
         if (itx_num_valid !== nvalid_t'(`ILK_WORDS))
            value_error("itx_num_valid", itx_num_valid, `ILK_WORDS);
         if (itx_eopbits !== '0) value_error("itx_eopbits", itx_eopbits, 0);
         bytes += int'(itx_num_valid) * 8;
         beat_idx++;
      end
   endtask

   // Outputs are sampled on the falling edge between register updates
   always @(negedge clk) begin
      if (tx_usr_srst) begin
         m_lfsr = 7'(`ILK_LFSR_SEED);
         m_chan = '0;
         beat_idx = 0;
         pkt_cnt = 0;
         sop_beats = 0;
      end else if (itx_num_valid != '0) begin
         check_beat();
      end
   end

   task automatic run_pkts(input int n, input bit rnd_ready);
      int target;
      target = pkt_cnt + n;
      while (pkt_cnt < target) begin
         @(posedge clk);
         #1;
         if (rnd_ready) itx_ready = ($urandom % 4) != 0;
      end
   endtask

   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 8) begin
         @(negedge clk);
         if (itx_num_valid == '0 && beat_idx == 0) quiet++;
         else quiet = 0;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic stop_and_drain();
      send_data = 1'b0;
      itx_ready = 1'b1;
      wait_idle();
   endtask

   task automatic finish_test(input string name);
      err_cnt += dut0.u_chk.fail_cnt - chk_seen;
      chk_seen = dut0.u_chk.fail_cnt;
      $display("%s: %s (%0d errors)", name, (err_cnt == test_err0) ? "ok" : "FAILED",
               err_cnt - test_err0);
      test_cnt++;
      if (err_cnt != test_err0) fail_tests++;
      test_err0 = err_cnt;
   endtask

   initial begin
      void'($urandom(8251));
      clk = 1'b0;
      tx_usr_srst = 1'b1;
      rx_lanes_aligned = 1'b0;
      send_data = 1'b0;
      rand_size = 1'b0;
      itx_ready = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      tx_usr_srst = 1'b0;
      rx_lanes_aligned = 1'b1;

      send_data = 1'b1;
      itx_ready = 1'b1;
      run_pkts(N_FIXED, 1'b0);
      stop_and_drain();
      finish_test("fixed size, ready high");

      rand_size = 1'b1;
      send_data = 1'b1;
      run_pkts(N_RAND, 1'b1);
      stop_and_drain();
      finish_test("random size, random ready");

      if (pkt_cnt <= 256) report_fault("channel number never wrapped past 255");
      if (chan_err != 0) report_fault("channel numbers out of order");
      finish_test("channel numbers");

      // Hold ready low while the sequencer sits between SOP and EOP
      rand_size = 1'b0;
      send_data = 1'b1;
      run_pkts(4, 1'b0);
      do @(negedge clk); while (!(itx_sop && itx_num_valid != '0));
      @(posedge clk);
      #1;
      itx_ready = 1'b0;
      send_data = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      p0 = pkt_cnt;
      s0 = sop_beats;
      itx_ready = 1'b1;
      wait_idle();
      if (pkt_cnt != p0 + 1) report_fault("held packet did not end with EOP");
      if (sop_beats != s0) report_fault("SOP sent after the enable dropped");
      // Random sizes after the restart show whether the LFSR kept its place
      rand_size = 1'b1;
      send_data = 1'b1;
      run_pkts(4, 1'b0);
      stop_and_drain();
      finish_test("enable dropped mid-packet");

      @(negedge clk);
      if (tx_sop_cnt !== pkt_cnt) value_error("tx_sop_cnt", tx_sop_cnt, pkt_cnt);
      if (tx_eop_cnt !== pkt_cnt) value_error("tx_eop_cnt", tx_eop_cnt, pkt_cnt);
      finish_test("statistics counters");

      @(posedge clk);
      #1;
      tx_usr_srst = 1'b1;
      rand_size = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      tx_usr_srst = 1'b0;
      @(negedge clk);
      if (itx_num_valid !== '0) value_error("itx_num_valid", itx_num_valid, 0);
      if (itx_sop !== 1'b0) value_error("itx_sop", itx_sop, 0);
      if (itx_eopbits !== '0) value_error("itx_eopbits", itx_eopbits, 0);
      if (tx_sop_cnt !== '0) value_error("tx_sop_cnt", tx_sop_cnt, 0);
      if (tx_eop_cnt !== '0) value_error("tx_eop_cnt", tx_eop_cnt, 0);
      @(posedge clk);
      #1;
      send_data = 1'b1;
      run_pkts(N_RESET, 1'b0);
      stop_and_drain();
      if (first_len != `ILK_LFSR_SEED + 1)
         value_error("first packet length", first_len, `ILK_LFSR_SEED + 1);
      finish_test("reset");

      $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
